//--- vlog.f
hdl/gpu_mem_pkg.sv
hdl/mem_addr_gen.sv
hdl/mem_cfg_regs.sv
hdl/mem_coalescer.sv
hdl/mem_scratchpad.sv
hdl/mem_gather.sv
hdl/gpu_mem_top.sv
bench/gpu_mem_props.sv
bench/gpu_mem_tb.sv

//--- run.sh
#!/bin/bash
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module gpu_mem_tb \
	-o sim_gpu_mem > build.log 2>&1 && ./obj_dir/sim_gpu_mem > sim.log 2>&1
grep -q "Regression passed" sim.log && echo "PASS" || { echo "FAIL (see build.log and sim.log)"; exit 1; }

//--- bench/gpu_mem_tb.sv
`timescale 1ns/10ps

module gpu_mem_tb;
	import gpu_mem_pkg::*;

	logic clk, arst_n_i, issue_i, mem_read_i, mem_write_i, shared_global_bar_i;
	warp_id_t warp_id_i;
	scb_id_t scb_id_i;
	pam_t pam_i;
	reg_addr_t reg_addr_i;
	lane_vec_t rs_reg_data_i, write_data_i, gmem_wdata_o, gmem_rdata_i, wb_data_o;
	logic [15:0] offset_i;
	logic stall_o, cfg_we_i, cfg_addr_i, gmem_req_o, gmem_we_o, gmem_ack_i;
	word_t cfg_wdata_i, cfg_rdata_o;
	line_addr_t gmem_line_o;
	logic [7:0] gmem_wmask_o;
	logic wb_valid_o, wb_read_o, wb_fault_o;
	warp_id_t wb_warp_id_o;
	scb_id_t wb_scb_id_o;
	reg_addr_t wb_reg_addr_o;

	gpu_mem_top gpu_mem_top_i (.*);

	logic [31:0] lfsr = 32'ha95ed477;
	lane_vec_t spm_ref [SPM_LINES];
	lane_vec_t gm_ref [line_addr_t];
	lane_vec_t gm_dut [line_addr_t];
	line_addr_t limit = line_addr_t'(SPM_LINES);
	lane_vec_t exp_data_q [$];
	logic exp_flt_q [$];
	warp_id_t exp_warp_q [$];
	scb_id_t exp_scb_q [$];
	reg_addr_t exp_reg_q [$];
	logic exp_rd_q [$];
	realtime issue_t_q [$];
	int last_lat;
	logic saw_stall = 1'b0;

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	// Fibonacci LFSR, taps 32 22 2 1.
	function automatic logic [31:0] rnd(input int nbits);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < nbits; i++)
		begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic lane_vec_t fill_line(input line_addr_t l);
		lane_vec_t v;
		for (int w = 0; w < LANES; w++)
			v[w*WORD_W +: WORD_W] = {l, w[2:0], 2'b00} ^ 32'hc3a5_0f1e;
		return v;
	endfunction

	// Serving rule applied line by line.
	task automatic predict(input logic rd, wr, sh, input pam_t pam, input lane_vec_t addr,
		input lane_vec_t wd, output lane_vec_t exp, output logic flt, output int lines);
		pam_t rem;
		line_addr_t l;
		lane_vec_t cur;
		int lead;
		logic [2:0] w;
		logic bad;
		rem = pam;
		exp = '0;
		flt = 1'b0;
		lines = 0;
		while (rem != '0)
		begin
			lead = 0;
			while (!rem[lead])
				lead++;
			l = addr[lead*WORD_W + 5 +: LINE_W];
			lines++;
			bad = sh && (l >= limit);
			if (sh)
				cur = spm_ref[l[5:0]];
			else
				cur = gm_ref.exists(l) ? gm_ref[l] : fill_line(l);
			for (int n = 0; n < LANES; n++)
			begin
				if (rem[n] && addr[n*WORD_W + 5 +: LINE_W] == l)
				begin
					w = addr[n*WORD_W + 2 +: 3];
					rem[n] = 1'b0;
					if (bad)
						flt = 1'b1;
					else if (rd)
						exp[n*WORD_W +: WORD_W] = cur[w*WORD_W +: WORD_W];
					else if (wr)
						cur[w*WORD_W +: WORD_W] = wd[n*WORD_W +: WORD_W]; // Highest lane last.
				end
			end
			if (wr && !bad && sh)
				spm_ref[l[5:0]] = cur;
			else if (wr && !bad)
				gm_ref[l] = cur;
		end
	endtask

	task automatic issue_op(input logic rd, wr, sh, input pam_t pam, input lane_vec_t base,
		input logic [15:0] off, input lane_vec_t wd, output int lines);
		lane_vec_t addr;
		lane_vec_t exp;
		logic flt;
		int t;
		for (int n = 0; n < LANES; n++)
			addr[n*WORD_W +: WORD_W] = base[n*WORD_W +: WORD_W] + {{16{off[15]}}, off};
		predict(rd, wr, sh, pam, addr, wd, exp, flt, lines);
		t = 0;
		while (stall_o)
		begin
			@(negedge clk);
			t++;
			if (t > 200)
				stop_run("Timeout while waiting for stall_o to drop.");
		end
		{mem_read_i, mem_write_i, shared_global_bar_i} = {rd, wr, sh};
		{pam_i, rs_reg_data_i, offset_i, write_data_i} = {pam, base, off, wd};
		warp_id_i = rnd(3);
		scb_id_i = rnd(2);
		reg_addr_i = rnd(5);
		issue_i = 1'b1;
		@(posedge clk);
		exp_data_q.push_back(exp);
		exp_flt_q.push_back(flt);
		exp_warp_q.push_back(warp_id_i);
		exp_scb_q.push_back(scb_id_i);
		exp_reg_q.push_back(reg_addr_i);
		exp_rd_q.push_back(rd);
		issue_t_q.push_back($realtime);
		@(negedge clk);
		issue_i = 1'b0;
	endtask

	task automatic wait_idle();
		int t;
		t = 0;
		while (exp_data_q.size() != 0)
		begin
			@(negedge clk);
			t++;
			if (t > 1000)
				stop_run("Timeout while waiting for a writeback.");
		end
	endtask

	task automatic check_lat(input int lines);
		assert (last_lat == 2 * lines + 3)
		else
			stop_run($sformatf("FAIL wb_valid_o latency got %h expected %h", last_lat, 2 * lines + 3));
	endtask

	// Shared address: line, word, ignored low bits.
	function automatic word_t sh_addr(input int line, input int w);
		return {21'b0, line[5:0], w[2:0], 2'(rnd(2))};
	endfunction

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	initial
	begin
		#2_000_000;
		stop_run("Simulation time limit reached.");
	end

	// Global memory with 0 to 7 cycles of latency.
	initial
	begin
		int d;
		line_addr_t l;
		lane_vec_t cur;
		gmem_ack_i = 1'b0;
		gmem_rdata_i = '0;
		forever
		begin
			@(negedge clk);
			gmem_ack_i = 1'b0;
			if (gmem_req_o)
			begin
				d = rnd(3);
				repeat (d) @(negedge clk);
				l = gmem_line_o;
				cur = gm_dut.exists(l) ? gm_dut[l] : fill_line(l);
				gmem_rdata_i = cur;
				for (int w = 0; w < LANES; w++)
					if (gmem_we_o && gmem_wmask_o[w])
						cur[w*WORD_W +: WORD_W] = gmem_wdata_o[w*WORD_W +: WORD_W];
				gm_dut[l] = cur;
				gmem_ack_i = 1'b1;
			end
		end
	end

	always @(negedge clk)
	begin
		if (stall_o && gmem_req_o)
			saw_stall = 1'b1;
		if (arst_n_i && wb_valid_o)
		begin
			if (exp_data_q.size() == 0)
				stop_run("Writeback arrived with no instruction outstanding.");
			last_lat = int'(($realtime - issue_t_q.pop_front() - 5) / 10);
			assert (wb_warp_id_o == exp_warp_q[0] && wb_scb_id_o == exp_scb_q[0])
			else
				stop_run($sformatf("FAIL wb_warp_id_o/wb_scb_id_o got %h/%h expected %h/%h",
					wb_warp_id_o, wb_scb_id_o, exp_warp_q[0], exp_scb_q[0]));
			assert (wb_reg_addr_o == exp_reg_q[0] && wb_read_o == exp_rd_q[0])
			else
				stop_run($sformatf("FAIL wb_reg_addr_o/wb_read_o got %h/%h expected %h/%h",
					wb_reg_addr_o, wb_read_o, exp_reg_q[0], exp_rd_q[0]));
			assert (wb_data_o == exp_data_q[0])
			else
				stop_run($sformatf("FAIL wb_data_o got %h expected %h", wb_data_o, exp_data_q[0]));
			assert (wb_fault_o == exp_flt_q[0])
			else
				stop_run($sformatf("FAIL wb_fault_o got %h expected %h", wb_fault_o, exp_flt_q[0]));
			void'(exp_data_q.pop_front());
			void'(exp_flt_q.pop_front());
			void'(exp_warp_q.pop_front());
			void'(exp_scb_q.pop_front());
			void'(exp_reg_q.pop_front());
			void'(exp_rd_q.pop_front());
		end
	end

	initial
	begin
		lane_vec_t base, wd;
		int lines;
		word_t c0, c1;
		logic rd;
		{arst_n_i, issue_i, mem_read_i, mem_write_i, shared_global_bar_i} = '0;
		{warp_id_i, scb_id_i, pam_i, reg_addr_i, offset_i} = '0;
		{rs_reg_data_i, write_data_i, cfg_we_i, cfg_addr_i, cfg_wdata_i} = '0;
		for (int i = 0; i < SPM_LINES; i++)
			spm_ref[i] = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		arst_n_i = 1'b1;
		// Fill shared lines 0 to 7 so later reads are defined.
		for (int l = 0; l < 8; l++)
		begin
			for (int n = 0; n < LANES; n++)
			begin
				base[n*WORD_W +: WORD_W] = sh_addr(l, n);
				wd[n*WORD_W +: WORD_W] = rnd(32);
			end
			issue_op(1'b0, 1'b1, 1'b1, 8'hff, base, 16'h0, wd, lines);
		end
		wait_idle();
		// Distinct lines, negative offset.
		for (int k = 0; k < 2; k++)
		begin
			for (int n = 0; n < LANES; n++)
			begin
				if (k == 0)
					base[n*WORD_W +: WORD_W] = sh_addr(7 - n, rnd(3)) + 32'd32;
				wd[n*WORD_W +: WORD_W] = rnd(32);
			end
			issue_op(k == 1, k == 0, 1'b1, 8'hff, base, 16'hffe0, wd, lines);
			wait_idle();
			check_lat(lines);
		end
		// One line with duplicate words.
		for (int k = 0; k < 2; k++)
		begin
			for (int n = 0; n < LANES; n++)
			begin
				if (k == 0)
					base[n*WORD_W +: WORD_W] = sh_addr(5, (n == 0 || n == 7) ? 0 : rnd(3));
				wd[n*WORD_W +: WORD_W] = rnd(32);
			end
			issue_op(k == 1, k == 0, 1'b1, 8'hff, base, 16'h0, wd, lines);
			wait_idle();
			check_lat(lines);
		end
		// Partial masks and the transaction counter.
		cfg_addr_i = 1'b1;
		@(negedge clk);
		for (int k = 0; k < 8; k++)
		begin
			c0 = cfg_rdata_o;
			for (int n = 0; n < LANES; n++)
			begin
				base[n*WORD_W +: WORD_W] = sh_addr(rnd(2), rnd(3));
				wd[n*WORD_W +: WORD_W] = rnd(32);
			end
			issue_op(k[0], !k[0], 1'b1, (k == 0) ? 8'h00 : 8'(rnd(8)), base, 16'h0, wd, lines);
			wait_idle();
			c1 = cfg_rdata_o;
			assert (c1 - c0 == word_t'(lines))
			else
				stop_run($sformatf("FAIL cfg_rdata_o got %h expected %h", c1 - c0, lines));
		end
		// Shared window limit.
		cfg_addr_i = 1'b0;
		cfg_we_i = 1'b1;
		cfg_wdata_i = 32'd4;
		@(negedge clk);
		cfg_we_i = 1'b0;
		limit = 27'd4;
		for (int n = 0; n < LANES; n++)
			base[n*WORD_W +: WORD_W] = sh_addr(n, rnd(3));
		issue_op(1'b1, 1'b0, 1'b1, 8'hff, base, 16'h0, '0, lines);
		wait_idle();
		cfg_we_i = 1'b1;
		cfg_wdata_i = SPM_LINES;
		@(negedge clk);
		cfg_we_i = 1'b0;
		limit = line_addr_t'(SPM_LINES);
		// Global path, issued back to back.
		for (int k = 0; k < 24; k++)
		begin
			for (int n = 0; n < LANES; n++)
			begin
				base[n*WORD_W +: WORD_W] = {27'h1000 + 27'(rnd(2)), 3'(rnd(3)), 2'b00};
				wd[n*WORD_W +: WORD_W] = rnd(32);
			end
			rd = rnd(1);
			issue_op(rd, !rd, 1'b0, 8'(rnd(8)), base, 16'h0, wd, lines);
		end
		wait_idle();
		if (saw_stall)
		begin
			$display("Regression passed");
			$finish;
		end
		else
			stop_run("stall_o never rose while a global request waited.");
	end

endmodule

//--- bench/gpu_mem_props.sv
`timescale 1ns/10ps

module gpu_mem_props (
	input logic                    clk,
	input logic                    arst_n_i,
	input logic                    stall_o,
	input logic                    gmem_req_o,
	input logic                    gmem_ack_i,
	input gpu_mem_pkg::line_addr_t gmem_line_o,
	input logic                    gmem_we_o,
	input logic [7:0]              gmem_wmask_o,
	input gpu_mem_pkg::lane_vec_t  gmem_wdata_o,
	input logic                    wb_valid_o
);

	// Request held with stable fields until acknowledge.
	req_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
		gmem_req_o && !gmem_ack_i |=> gmem_req_o && $stable(gmem_line_o) && $stable(gmem_we_o)
		&& $stable(gmem_wmask_o) && $stable(gmem_wdata_o))
	else
		$error("gmem request changed before acknowledge");

	req_drop: assert property (@(posedge clk) disable iff (!arst_n_i)
		gmem_req_o && gmem_ack_i |=> !gmem_req_o)
	else
		$error("gmem_req_o held after acknowledge");

	wb_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
		wb_valid_o |=> !wb_valid_o)
	else
		$error("wb_valid_o longer than one cycle");

	in_reset: assert property (@(posedge clk)
		!arst_n_i |-> !stall_o && !gmem_req_o && !wb_valid_o)
	else
		$error("outputs active during reset");

endmodule

bind gpu_mem_top gpu_mem_props gpu_mem_props_i (
	.clk(clk),
	.arst_n_i(arst_n_i),
	.stall_o(stall_o),
	.gmem_req_o(gmem_req_o),
	.gmem_ack_i(gmem_ack_i),
	.gmem_line_o(gmem_line_o),
	.gmem_we_o(gmem_we_o),
	.gmem_wmask_o(gmem_wmask_o),
	.gmem_wdata_o(gmem_wdata_o),
	.wb_valid_o(wb_valid_o)
);

//--- hdl/gpu_mem_top.sv
`timescale 1ns/10ps

module gpu_mem_top (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  logic                   issue_i,
	input  logic                   mem_read_i,
	input  logic                   mem_write_i,
	input  logic                   shared_global_bar_i,
	input  gpu_mem_pkg::warp_id_t  warp_id_i,
	input  gpu_mem_pkg::scb_id_t   scb_id_i,
	input  gpu_mem_pkg::pam_t      pam_i,
	input  gpu_mem_pkg::reg_addr_t reg_addr_i,
	input  gpu_mem_pkg::lane_vec_t rs_reg_data_i,
	input  logic [15:0]            offset_i,
	input  gpu_mem_pkg::lane_vec_t write_data_i,
	output logic                   stall_o,
	input  logic                   cfg_we_i,
	input  logic                   cfg_addr_i,
	input  gpu_mem_pkg::word_t     cfg_wdata_i,
	output gpu_mem_pkg::word_t     cfg_rdata_o,
	output logic                   gmem_req_o,
	output gpu_mem_pkg::line_addr_t gmem_line_o,
	output logic                   gmem_we_o,
	output logic [7:0]             gmem_wmask_o,
	output gpu_mem_pkg::lane_vec_t gmem_wdata_o,
	input  logic                   gmem_ack_i,
	input  gpu_mem_pkg::lane_vec_t gmem_rdata_i,
	output logic                   wb_valid_o,
	output gpu_mem_pkg::warp_id_t  wb_warp_id_o,
	output gpu_mem_pkg::scb_id_t   wb_scb_id_o,
	output gpu_mem_pkg::reg_addr_t wb_reg_addr_o,
	output logic                   wb_read_o,
	output gpu_mem_pkg::lane_vec_t wb_data_o,
	output logic                   wb_fault_o
);
	import gpu_mem_pkg::*;

	logic valid, take, read, write, shared;
	warp_id_t warp_id;
	scb_id_t scb_id;
	pam_t pam;
	reg_addr_t reg_addr;
	lane_vec_t eff_addr, write_data;
	line_addr_t shared_limit;
	logic spm_en, spm_we;
	spm_idx_t spm_idx;
	logic [7:0] spm_wmask;
	lane_vec_t spm_wdata, spm_rdata;
	pam_t lane_we;
	lane_vec_t line_data;
	logic fault, finish, line_done;

	mem_addr_gen mem_addr_gen_i (
		.clk, .arst_n_i, .issue_i, .take_i(take), .mem_read_i, .mem_write_i,
		.shared_global_bar_i, .warp_id_i, .scb_id_i, .pam_i, .reg_addr_i,
		.rs_reg_data_i, .offset_i, .write_data_i, .valid_o(valid), .stall_o,
		.read_o(read), .write_o(write), .shared_o(shared), .warp_id_o(warp_id),
		.scb_id_o(scb_id), .pam_o(pam), .reg_addr_o(reg_addr),
		.eff_addr_o(eff_addr), .write_data_o(write_data)
	);

	mem_cfg_regs mem_cfg_regs_i (
		.clk, .arst_n_i, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i,
		.line_done_i(line_done), .cfg_rdata_o, .shared_limit_o(shared_limit)
	);

	mem_coalescer mem_coalescer_i (
		.clk, .arst_n_i, .valid_i(valid), .read_i(read), .write_i(write),
		.shared_i(shared), .pam_i(pam), .eff_addr_i(eff_addr),
		.write_data_i(write_data), .shared_limit_i(shared_limit),
		.spm_rdata_i(spm_rdata), .gmem_ack_i, .gmem_rdata_i, .take_o(take),
		.spm_en_o(spm_en), .spm_we_o(spm_we), .spm_idx_o(spm_idx),
		.spm_wmask_o(spm_wmask), .spm_wdata_o(spm_wdata), .gmem_req_o,
		.gmem_line_o, .gmem_we_o, .gmem_wmask_o, .gmem_wdata_o,
		.lane_we_o(lane_we), .line_data_o(line_data), .fault_o(fault),
		.finish_o(finish), .line_done_o(line_done)
	);

	mem_scratchpad mem_scratchpad_i (
		.clk, .en_i(spm_en), .we_i(spm_we), .idx_i(spm_idx),
		.wmask_i(spm_wmask), .wdata_i(spm_wdata), .rdata_o(spm_rdata)
	);

	mem_gather mem_gather_i (
		.clk, .arst_n_i, .take_i(take), .warp_id_i(warp_id), .scb_id_i(scb_id),
		.reg_addr_i(reg_addr), .read_i(read), .eff_addr_i(eff_addr),
		.lane_we_i(lane_we), .line_data_i(line_data), .fault_i(fault),
		.finish_i(finish), .wb_valid_o, .wb_warp_id_o, .wb_scb_id_o,
		.wb_reg_addr_o, .wb_read_o, .wb_data_o, .wb_fault_o
	);

endmodule

//--- hdl/mem_gather.sv
`timescale 1ns/10ps

module mem_gather (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  logic                   take_i,
	input  gpu_mem_pkg::warp_id_t  warp_id_i,
	input  gpu_mem_pkg::scb_id_t   scb_id_i,
	input  gpu_mem_pkg::reg_addr_t reg_addr_i,
	input  logic                   read_i,
	input  gpu_mem_pkg::lane_vec_t eff_addr_i,
	input  gpu_mem_pkg::pam_t      lane_we_i,
	input  gpu_mem_pkg::lane_vec_t line_data_i,
	input  logic                   fault_i,
	input  logic                   finish_i,
	output logic                   wb_valid_o,
	output gpu_mem_pkg::warp_id_t  wb_warp_id_o,
	output gpu_mem_pkg::scb_id_t   wb_scb_id_o,
	output gpu_mem_pkg::reg_addr_t wb_reg_addr_o,
	output logic                   wb_read_o,
	output gpu_mem_pkg::lane_vec_t wb_data_o,
	output logic                   wb_fault_o
);
	import gpu_mem_pkg::*;

	lane_idx_t word_sel [LANES]; // Word of the line per lane.

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			wb_valid_o <= 1'b0;
		else
			wb_valid_o <= finish_i;
	end

	always_ff @(posedge clk)
	begin
		if (take_i)
		begin
			wb_warp_id_o <= warp_id_i;
			wb_scb_id_o <= scb_id_i;
			wb_reg_addr_o <= reg_addr_i;
			wb_read_o <= read_i;
			wb_data_o <= '0; // Inactive lanes stay zero.
			wb_fault_o <= 1'b0;
			for (int n = 0; n < LANES; n++)
				word_sel[n] <= eff_addr_i[n*WORD_W + 2 +: 3];
		end
		else
		begin
			wb_fault_o <= wb_fault_o | fault_i;
			for (int n = 0; n < LANES; n++)
			begin
				if (lane_we_i[n])
					wb_data_o[n*WORD_W +: WORD_W] <= line_data_i[word_sel[n]*WORD_W +: WORD_W];
			end
		end
	end

endmodule

//--- hdl/mem_scratchpad.sv
`timescale 1ns/10ps

module mem_scratchpad (
	input  logic                   clk,
	input  logic                   en_i,
	input  logic                   we_i,
	input  gpu_mem_pkg::spm_idx_t  idx_i,
	input  logic [7:0]             wmask_i,
	input  gpu_mem_pkg::lane_vec_t wdata_i,
	output gpu_mem_pkg::lane_vec_t rdata_o
);
	import gpu_mem_pkg::*;

	lane_vec_t mem [SPM_LINES];

	// Read first, so a write cycle returns the old line.
	always_ff @(posedge clk)
	begin
		if (en_i)
			rdata_o <= mem[idx_i];
	end

	always_ff @(posedge clk)
	begin
		if (en_i && we_i)
		begin
			for (int w = 0; w < LANES; w++)
			begin
				if (wmask_i[w])
					mem[idx_i][w*WORD_W +: WORD_W] <= wdata_i[w*WORD_W +: WORD_W];
			end
		end
	end

endmodule

//--- hdl/mem_coalescer.sv
`timescale 1ns/10ps

module mem_coalescer (
	input  logic                    clk,
	input  logic                    arst_n_i,
	input  logic                    valid_i,
	input  logic                    read_i,
	input  logic                    write_i,
	input  logic                    shared_i,
	input  gpu_mem_pkg::pam_t       pam_i,
	input  gpu_mem_pkg::lane_vec_t  eff_addr_i,
	input  gpu_mem_pkg::lane_vec_t  write_data_i,
	input  gpu_mem_pkg::line_addr_t shared_limit_i,
	input  gpu_mem_pkg::lane_vec_t  spm_rdata_i,
	input  logic                    gmem_ack_i,
	input  gpu_mem_pkg::lane_vec_t  gmem_rdata_i,
	output logic                    take_o,
	output logic                    spm_en_o,
	output logic                    spm_we_o,
	output gpu_mem_pkg::spm_idx_t   spm_idx_o,
	output logic [7:0]              spm_wmask_o,
	output gpu_mem_pkg::lane_vec_t  spm_wdata_o,
	output logic                    gmem_req_o,
	output gpu_mem_pkg::line_addr_t gmem_line_o,
	output logic                    gmem_we_o,
	output logic [7:0]              gmem_wmask_o,
	output gpu_mem_pkg::lane_vec_t  gmem_wdata_o,
	output gpu_mem_pkg::pam_t       lane_we_o,
	output gpu_mem_pkg::lane_vec_t  line_data_o,
	output logic                    fault_o,
	output logic                    finish_o,
	output logic                    line_done_o
);
	import gpu_mem_pkg::*;

	coal_state_t state;
	pam_t rem; // Lanes still to serve.
	lane_vec_t eff_r;
	lane_vec_t wdata_r;
	logic read_r;
	logic write_r;
	logic shared_r;

	lane_idx_t lead;
	line_addr_t line;
	pam_t served;
	logic [LANES-1:0] wmask;
	lane_vec_t wline;
	logic line_fault;
	logic step_pick;

	// Lowest remaining lane sets the line.
	always_comb
	begin
		lead = '0;
		for (int n = LANES - 1; n >= 0; n--)
			if (rem[n])
				lead = lane_idx_t'(n);
	end

	assign line = eff_r[lead*WORD_W + 5 +: LINE_W];

	// Ascending order, so the highest lane owns a shared word.
	always_comb
	begin
		lane_idx_t w;
		served = '0;
		wmask = '0;
		wline = '0;
		for (int n = 0; n < LANES; n++)
		begin
			w = eff_r[n*WORD_W + 2 +: 3];
			if (rem[n] && eff_r[n*WORD_W + 5 +: LINE_W] == line)
			begin
				served[n] = 1'b1;
				wmask[w] = 1'b1;
				wline[w*WORD_W +: WORD_W] = wdata_r[n*WORD_W +: WORD_W];
			end
		end
	end

	assign line_fault = shared_r && (line >= shared_limit_i);
	assign step_pick = (state == PICK) && (rem != '0);

	assign take_o = (state == IDLE) && valid_i;
	assign spm_en_o = step_pick && shared_r && !line_fault;
	assign spm_we_o = spm_en_o && write_r;
	assign spm_idx_o = line[5:0];
	assign spm_wmask_o = wmask;
	assign spm_wdata_o = wline;

	// Fields hold because rem only changes when the line step ends.
	assign gmem_req_o = (state == GMEM_WAIT);
	assign gmem_line_o = line;
	assign gmem_we_o = write_r;
	assign gmem_wmask_o = wmask;
	assign gmem_wdata_o = wline;

	always_comb
	begin
		lane_we_o = '0;
		line_data_o = '0;
		if (step_pick && line_fault)
			lane_we_o = served; // Faulted lanes read zero.
		else if (state == SPM_RD)
		begin
			lane_we_o = served;
			line_data_o = read_r ? spm_rdata_i : '0;
		end
		else if (gmem_req_o && gmem_ack_i)
		begin
			lane_we_o = served;
			line_data_o = read_r ? gmem_rdata_i : '0;
		end
	end

	assign fault_o = step_pick && line_fault;
	assign finish_o = (state == FINISH);
	assign line_done_o = |lane_we_o;

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			state <= IDLE;
			rem <= '0;
		end
		else
		begin
			case (state)
				IDLE:
					if (valid_i)
					begin
						rem <= pam_i;
						state <= PICK;
					end
				PICK:
					if (rem == '0)
						state <= FINISH;
					else if (line_fault)
						rem <= rem & ~served; // One cycle step.
					else if (shared_r)
						state <= SPM_RD;
					else
						state <= GMEM_WAIT;
				SPM_RD:
				begin
					rem <= rem & ~served;
					state <= PICK;
				end
				GMEM_WAIT:
					if (gmem_ack_i)
					begin
						rem <= rem & ~served;
						state <= PICK;
					end
				default:
					state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (take_o)
		begin
			eff_r <= eff_addr_i;
			wdata_r <= write_data_i;
			read_r <= read_i;
			write_r <= write_i;
			shared_r <= shared_i;
		end
	end

endmodule

//--- hdl/mem_cfg_regs.sv
`timescale 1ns/10ps

module mem_cfg_regs (
	input  logic                    clk,
	input  logic                    arst_n_i,
	input  logic                    cfg_we_i,
	input  logic                    cfg_addr_i,
	input  gpu_mem_pkg::word_t      cfg_wdata_i,
	input  logic                    line_done_i,
	output gpu_mem_pkg::word_t      cfg_rdata_o,
	output gpu_mem_pkg::line_addr_t shared_limit_o
);
	import gpu_mem_pkg::*;

	word_t txn_count;

	// Shared lines at or above the limit fault.
	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			shared_limit_o <= line_addr_t'(SPM_LINES);
		else if (cfg_we_i && !cfg_addr_i)
			shared_limit_o <= cfg_wdata_i[LINE_W-1:0];
	end

	// Address 1 is read only.
	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			txn_count <= '0;
		else if (line_done_i)
			txn_count <= txn_count + 1'b1; // Wraps.
	end

	assign cfg_rdata_o = cfg_addr_i ? txn_count : word_t'(shared_limit_o);

endmodule

//--- hdl/mem_addr_gen.sv
`timescale 1ns/10ps

module mem_addr_gen (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  logic                  issue_i,
	input  logic                  take_i,
	input  logic                  mem_read_i,
	input  logic                  mem_write_i,
	input  logic                  shared_global_bar_i,
	input  gpu_mem_pkg::warp_id_t warp_id_i,
	input  gpu_mem_pkg::scb_id_t  scb_id_i,
	input  gpu_mem_pkg::pam_t     pam_i,
	input  gpu_mem_pkg::reg_addr_t reg_addr_i,
	input  gpu_mem_pkg::lane_vec_t rs_reg_data_i,
	input  logic [15:0]           offset_i,
	input  gpu_mem_pkg::lane_vec_t write_data_i,
	output logic                  valid_o,
	output logic                  stall_o,
	output logic                  read_o,
	output logic                  write_o,
	output logic                  shared_o,
	output gpu_mem_pkg::warp_id_t warp_id_o,
	output gpu_mem_pkg::scb_id_t  scb_id_o,
	output gpu_mem_pkg::pam_t     pam_o,
	output gpu_mem_pkg::reg_addr_t reg_addr_o,
	output gpu_mem_pkg::lane_vec_t eff_addr_o,
	output gpu_mem_pkg::lane_vec_t write_data_o
);
	import gpu_mem_pkg::*;

	word_t offset_ext;
	lane_vec_t eff_addr;
	logic load;

	assign offset_ext = {{16{offset_i[15]}}, offset_i};

	always_comb
	begin
		for (int n = 0; n < LANES; n++)
			eff_addr[n*WORD_W +: WORD_W] = rs_reg_data_i[n*WORD_W +: WORD_W] + offset_ext;
	end

	// Entry is free when empty or being consumed this cycle.
	assign stall_o = valid_o && !take_i;
	assign load = issue_i && !stall_o;

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			valid_o <= 1'b0;
		else if (load)
			valid_o <= 1'b1;
		else if (take_i)
			valid_o <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			read_o       <= mem_read_i;
			write_o      <= mem_write_i;
			shared_o     <= shared_global_bar_i;
			warp_id_o    <= warp_id_i;
			scb_id_o     <= scb_id_i;
			pam_o        <= pam_i;
			reg_addr_o   <= reg_addr_i;
			eff_addr_o   <= eff_addr;
			write_data_o <= write_data_i;
		end
	end

endmodule

//--- hdl/gpu_mem_pkg.sv
package gpu_mem_pkg;

	localparam int LANES = 8;
	localparam int WORD_W = 32;
	localparam int LINE_W = 27; // Address bits 31:5.
	localparam int SPM_LINES = 64;

	// One lane's address or data word.
	typedef logic [WORD_W-1:0] word_t;

	// Eight words, lane n at bits 32n upward.
	typedef logic [LANES*WORD_W-1:0] lane_vec_t;

	typedef logic [LANES-1:0] pam_t; // Active lane mask.
	typedef logic [2:0] warp_id_t;
	typedef logic [1:0] scb_id_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [LINE_W-1:0] line_addr_t;
	typedef logic [$clog2(SPM_LINES)-1:0] spm_idx_t;

	// Lane number, also word number inside a line.
	typedef logic [$clog2(LANES)-1:0] lane_idx_t;

	typedef enum logic [2:0]
	{
		IDLE,
		PICK,
		SPM_RD,
		GMEM_WAIT,
		FINISH
	} coal_state_t;

endpackage
